// ==== sim.f ====
hdl/rv32i_ops_pkg.sv
hdl/rob_types_pkg.sv
hdl/dispatch.sv
hdl/exec_lanes.sv
hdl/reorder_buffer.sv
hdl/commit_unit.sv
hdl/ooo_core_top.sv
dv/tb_ooo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the out-of-order core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_ooo_core \
	-f sim.f \
	-o sim_ooo_core

./obj_dir/sim_ooo_core 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

if ! grep -q "all tests passed" sim.log; then
	echo "Simulation ended without a pass report, see sim.log"
	exit 1
fi

echo "Simulation finished cleanly"

// ==== dv/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;
	import rv32i_ops_pkg::*;
	import rob_types_pkg::*;

	typedef enum {
		ready_always,
		ready_random,
		ready_held
	} ready_mode_e;

	localparam int accept_timeout = 200;
	localparam int drain_timeout  = 2000;
	localparam int fill_timeout   = 500;
	localparam int stall_window   = 30;

	logic     clk;
	logic     rst;
	logic     instr_valid;
	logic     instr_ready;
	op_e      instr_op;
	reg_idx_t instr_rd;
	word_t    instr_a;
	word_t    instr_b;
	logic     retire_valid;
	logic     retire_ready;
	reg_idx_t retire_rd;
	word_t    retire_data;
	reg_idx_t reg_addr;
	word_t    reg_data;

	// Stimulus table with one row per instruction
	op_e      tbl_op [$];
	reg_idx_t tbl_rd [$];
	word_t    tbl_a  [$];
	word_t    tbl_b  [$];

	// Reference model with expected retirements kept in program order
	reg_idx_t    exp_rd_q   [$];
	word_t       exp_data_q [$];
	word_t       model_regs [num_regs];
	ready_mode_e ready_mode;
	logic [31:0] rand_state;
	int          retired;

	ooo_core_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.instr_op     (instr_op),
		.instr_rd     (instr_rd),
		.instr_a      (instr_a),
		.instr_b      (instr_b),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data)
	);

	always #20 clk = ~clk;

	function automatic word_t ref_result(input op_e op, input word_t a, input word_t b);
		logic [63:0] prod;
		word_t       res;
		prod = {32'b0, a} * {32'b0, b};
		case (op)
			op_add:  res = a + b;
			op_sub:  res = a - b;
			op_and:  res = a & b;
			op_or:   res = a | b;
			op_xor:  res = a ^ b;
			op_sll:  res = a << b[4:0];
			op_srl:  res = a >> b[4:0];
			op_mul:  res = prod[31:0];
			default: res = 'x;
		endcase
		return res;
	endfunction

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic add_entry(input op_e op, input reg_idx_t rd, input word_t a, input word_t b);
		tbl_op.push_back(op);
		tbl_rd.push_back(rd);
		tbl_a.push_back(a);
		tbl_b.push_back(b);
	endtask

	task automatic check_retirement();
		if (exp_rd_q.size() == 0) begin
			$display("Retirement at %0d ns with no instruction outstanding", $time);
			abort_run();
		end else begin
			check_reg_idx("retire_rd", retire_rd, exp_rd_q.pop_front());
			check_word("retire_data", retire_data, exp_data_q.pop_front());
			retired++;
		end
	endtask

	// Sample the retirement stream at each clock edge and then drive retire_ready
	task automatic tick();
		@(posedge clk);
		if (retire_valid && retire_ready) begin
			check_retirement();
		end
		case (ready_mode)
			ready_always: retire_ready <= 1'b1;
			ready_held:   retire_ready <= 1'b0;
			default: begin
				rand_state = next_rand(rand_state);
				retire_ready <= rand_state[3];
			end
		endcase
	endtask

	task automatic present_instr(input int idx);
		instr_valid <= 1'b1;
		instr_op    <= tbl_op[idx];
		instr_rd    <= tbl_rd[idx];
		instr_a     <= tbl_a[idx];
		instr_b     <= tbl_b[idx];
	endtask

	task automatic push_expected(input int idx);
		word_t res;
		res = ref_result(tbl_op[idx], tbl_a[idx], tbl_b[idx]);
		exp_rd_q.push_back(tbl_rd[idx]);
		exp_data_q.push_back(res);
		if (tbl_rd[idx] != '0) begin
			model_regs[tbl_rd[idx]] = res;
		end
	endtask

	task automatic send_instr(input int idx);
		int   waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		present_instr(idx);
		while (!taken) begin
			if (waited == accept_timeout) begin
				$display("Timeout: instruction %0d was never accepted", idx);
				abort_run();
			end
			tick();
			waited++;
			taken = instr_ready;
		end
		push_expected(idx);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_rd_q.size() != 0) begin
			if (waited == drain_timeout) begin
				$display("Timeout: %0d instructions never retired", exp_rd_q.size());
				abort_run();
			end
			tick();
			waited++;
		end
	endtask

	task automatic run_table(input ready_mode_e mode);
		ready_mode = mode;
		for (int i = 0; i < tbl_op.size(); i++) begin
			send_instr(i);
		end
		instr_valid <= 1'b0;
		drain();
	endtask

	// Hold retire_ready low until acceptance stops, then release the stream
	task automatic run_stalled();
		int idx;
		int idle;
		int accepted;
		int cycles;
		idx = 0;
		idle = 0;
		accepted = 0;
		cycles = 0;
		ready_mode = ready_held;
		present_instr(idx);
		while (idle < stall_window) begin
			if (cycles == fill_timeout) begin
				$display("Timeout: acceptance never stopped with retire_ready low");
				abort_run();
			end
			tick();
			cycles++;
			if (instr_valid && instr_ready) begin
				push_expected(idx);
				accepted++;
				idx++;
				idle = 0;
				if (idx < tbl_op.size()) begin
					present_instr(idx);
				end else begin
					instr_valid <= 1'b0;
				end
			end else begin
				idle++;
			end
		end
		if (accepted != rob_size + 1) begin
			$display("Accepted %0d instructions under back-pressure, expected %0d",
				accepted, rob_size + 1);
			abort_run();
		end
		ready_mode = ready_always;
		for (int i = idx; i < tbl_op.size(); i++) begin
			send_instr(i);
		end
		instr_valid <= 1'b0;
		drain();
	endtask

	task automatic check_registers();
		for (int r = 0; r < num_regs; r++) begin
			reg_addr <= reg_idx_t'(r);
			tick();
			check_word($sformatf("reg_data[%0d]", r), reg_data, model_regs[r]);
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		instr_valid  = 1'b0;
		instr_op     = op_add;
		instr_rd     = '0;
		instr_a      = '0;
		instr_b      = '0;
		retire_ready = 1'b1;
		reg_addr     = '0;
		ready_mode   = ready_always;
		rand_state   = 32'h5369af88;
		retired      = 0;
		for (int r = 0; r < num_regs; r++) begin
			model_regs[r] = '0;
		end

		// Multiply ahead of ALU work, an rd of x0, and shift amounts above 31
		add_entry(op_add, 5'd1, 32'd5, 32'd7);
		add_entry(op_sub, 5'd2, 32'd3, 32'd10);
		add_entry(op_mul, 5'd3, 32'h1234_5678, 32'h9abc_def0);
		add_entry(op_and, 5'd4, 32'hf0f0_ff00, 32'h3c3c_0ff0);
		add_entry(op_or, 5'd5, 32'h0000_00f0, 32'h0f00_000f);
		add_entry(op_xor, 5'd6, 32'hdead_beef, 32'hffff_0000);
		add_entry(op_sll, 5'd7, 32'h0000_0001, 32'h0000_0023);
		add_entry(op_srl, 5'd8, 32'h8000_0000, 32'h0000_003f);
		add_entry(op_add, 5'd0, 32'h0000_0011, 32'h0000_0022);
		add_entry(op_mul, 5'd9, 32'hffff_ffff, 32'hffff_ffff);
		add_entry(op_add, 5'd10, 32'h7fff_ffff, 32'h0000_0001);
		add_entry(op_sub, 5'd1, 32'h0000_0000, 32'h0000_0001);
		add_entry(op_mul, 5'd11, 32'd3, 32'd5);
		add_entry(op_xor, 5'd12, 32'h1234_5678, 32'h1234_5678);

		repeat (2) tick();
		rst <= 1'b0;
		tick();

		run_table(ready_always);
		run_table(ready_random);
		run_stalled();
		check_registers();

		if (retired != 3 * tbl_op.size()) begin
			$display("Retired %0d instructions, expected %0d", retired, 3 * tbl_op.size());
			abort_run();
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== hdl/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    instr_valid,
	output logic                    instr_ready,
	input  rv32i_ops_pkg::op_e      instr_op,
	input  rv32i_ops_pkg::reg_idx_t instr_rd,
	input  rv32i_ops_pkg::word_t    instr_a,
	input  rv32i_ops_pkg::word_t    instr_b,

	output logic                    retire_valid,
	input  logic                    retire_ready,
	output rv32i_ops_pkg::reg_idx_t retire_rd,
	output rv32i_ops_pkg::word_t    retire_data,

	input  rv32i_ops_pkg::reg_idx_t reg_addr,
	output rv32i_ops_pkg::word_t    reg_data
);
	import rv32i_ops_pkg::*;
	import rob_types_pkg::*;

	// Allocation
	logic     alloc_valid;
	reg_idx_t alloc_rd;
	logic     alloc_ready;
	rob_tag_t alloc_tag;

	// Issue
	logic     issue_valid;
	lane_e    issue_lane;
	op_e      issue_op;
	rob_tag_t issue_tag;
	word_t    issue_a;
	word_t    issue_b;
	logic     mul_busy;

	// Completion
	logic     alu_done_valid;
	rob_tag_t alu_done_tag;
	word_t    alu_done_data;
	logic     mul_done_valid;
	rob_tag_t mul_done_tag;
	word_t    mul_done_data;

	// Head toward commit
	logic     head_valid;
	logic     head_ready;
	reg_idx_t head_rd;
	word_t    head_data;

	dispatch u_dispatch (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr_op    (instr_op),
		.instr_rd    (instr_rd),
		.instr_a     (instr_a),
		.instr_b     (instr_b),
		.alloc_valid (alloc_valid),
		.alloc_rd    (alloc_rd),
		.alloc_ready (alloc_ready),
		.alloc_tag   (alloc_tag),
		.issue_valid (issue_valid),
		.issue_lane  (issue_lane),
		.issue_op    (issue_op),
		.issue_tag   (issue_tag),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.mul_busy    (mul_busy)
	);

	exec_lanes u_exec_lanes (
		.clk            (clk),
		.rst            (rst),
		.issue_valid    (issue_valid),
		.issue_lane     (issue_lane),
		.issue_op       (issue_op),
		.issue_tag      (issue_tag),
		.issue_a        (issue_a),
		.issue_b        (issue_b),
		.mul_busy       (mul_busy),
		.alu_done_valid (alu_done_valid),
		.alu_done_tag   (alu_done_tag),
		.alu_done_data  (alu_done_data),
		.mul_done_valid (mul_done_valid),
		.mul_done_tag   (mul_done_tag),
		.mul_done_data  (mul_done_data)
	);

	reorder_buffer u_reorder_buffer (
		.clk            (clk),
		.rst            (rst),
		.alloc_valid    (alloc_valid),
		.alloc_rd       (alloc_rd),
		.alloc_ready    (alloc_ready),
		.alloc_tag      (alloc_tag),
		.alu_done_valid (alu_done_valid),
		.alu_done_tag   (alu_done_tag),
		.alu_done_data  (alu_done_data),
		.mul_done_valid (mul_done_valid),
		.mul_done_tag   (mul_done_tag),
		.mul_done_data  (mul_done_data),
		.head_valid     (head_valid),
		.head_ready     (head_ready),
		.head_rd        (head_rd),
		.head_data      (head_data)
	);

	commit_unit u_commit_unit (
		.clk          (clk),
		.rst          (rst),
		.head_valid   (head_valid),
		.head_ready   (head_ready),
		.head_rd      (head_rd),
		.head_data    (head_data),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data)
	);

endmodule

// ==== hdl/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
	input  logic                    clk,
	input  logic                    rst,

	// Head of the reorder buffer
	input  logic                    head_valid,
	output logic                    head_ready,
	input  rv32i_ops_pkg::reg_idx_t head_rd,
	input  rv32i_ops_pkg::word_t    head_data,

	// Retirement stream
	output logic                    retire_valid,
	input  logic                    retire_ready,
	output rv32i_ops_pkg::reg_idx_t retire_rd,
	output rv32i_ops_pkg::word_t    retire_data,

	// Architectural register read port
	input  rv32i_ops_pkg::reg_idx_t reg_addr,
	output rv32i_ops_pkg::word_t    reg_data
);
	import rv32i_ops_pkg::*;

	word_t regs [num_regs];
	logic  take;

	// Room when the retire register is empty or drains this cycle
	assign head_ready = !retire_valid || retire_ready;
	assign take       = head_valid && head_ready;

	assign reg_data = regs[reg_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else if (take) begin
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			retire_rd   <= head_rd;
			retire_data <= head_data;
		end
	end

	// x0 is never written so it reads back as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (take && (head_rd != '0)) begin
			regs[head_rd] <= head_data;
		end
	end

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
	input  logic                    clk,
	input  logic                    rst,

	// Allocation from dispatch
	input  logic                    alloc_valid,
	input  rv32i_ops_pkg::reg_idx_t alloc_rd,
	output logic                    alloc_ready,
	output rob_types_pkg::rob_tag_t alloc_tag,

	// Completion buses that are always accepted
	input  logic                    alu_done_valid,
	input  rob_types_pkg::rob_tag_t alu_done_tag,
	input  rv32i_ops_pkg::word_t    alu_done_data,
	input  logic                    mul_done_valid,
	input  rob_types_pkg::rob_tag_t mul_done_tag,
	input  rv32i_ops_pkg::word_t    mul_done_data,

	// Oldest entry toward commit
	output logic                    head_valid,
	input  logic                    head_ready,
	output rv32i_ops_pkg::reg_idx_t head_rd,
	output rv32i_ops_pkg::word_t    head_data
);
	import rv32i_ops_pkg::*;
	import rob_types_pkg::*;

	logic     ent_busy [rob_size];
	logic     ent_done [rob_size];
	reg_idx_t ent_rd   [rob_size];
	word_t    ent_data [rob_size];

	rob_tag_t head_ptr;
	rob_tag_t tail_ptr;
	rob_cnt_t count;
	logic     do_alloc;
	logic     do_retire;

	function automatic rob_tag_t next_ptr(rob_tag_t ptr);
		rob_tag_t nxt;
		if (ptr == rob_tag_t'(rob_size - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// New entries always go to the tail
	assign alloc_ready = (count != rob_cnt_t'(rob_size));
	assign alloc_tag   = tail_ptr;
	assign do_alloc    = alloc_valid && alloc_ready;

	// Head is offered only once its result has come back
	assign head_valid = ent_busy[head_ptr] && ent_done[head_ptr];
	assign head_rd    = ent_rd[head_ptr];
	assign head_data  = ent_data[head_ptr];
	assign do_retire  = head_valid && head_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (do_alloc) begin
				tail_ptr <= next_ptr(tail_ptr);
			end
			if (do_retire) begin
				head_ptr <= next_ptr(head_ptr);
			end
			if (do_alloc && !do_retire) begin
				count <= count + 1'b1;
			end else if (!do_alloc && do_retire) begin
				count <= count - 1'b1;
			end
		end
	end

	// Head and tail only meet when the buffer is full or empty,
	// and then only one of allocate or retire can fire
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rob_size; i++) begin
				ent_busy[i] <= 1'b0;
				ent_done[i] <= 1'b0;
			end
		end else begin
			if (do_retire) begin
				ent_busy[head_ptr] <= 1'b0;
				ent_done[head_ptr] <= 1'b0;
			end
			if (do_alloc) begin
				ent_busy[tail_ptr] <= 1'b1;
				ent_done[tail_ptr] <= 1'b0;
			end
			if (alu_done_valid) begin
				ent_done[alu_done_tag] <= 1'b1;
			end
			if (mul_done_valid) begin
				ent_done[mul_done_tag] <= 1'b1;
			end
		end
	end

	// Two completions in one cycle always carry different tags
	always_ff @(posedge clk) begin
		if (do_alloc) begin
			ent_rd[tail_ptr] <= alloc_rd;
		end
		if (alu_done_valid) begin
			ent_data[alu_done_tag] <= alu_done_data;
		end
		if (mul_done_valid) begin
			ent_data[mul_done_tag] <= mul_done_data;
		end
	end

endmodule

// ==== hdl/exec_lanes.sv ====
`timescale 1ns/1ps

module exec_lanes (
	input  logic                    clk,
	input  logic                    rst,

	// Issue from dispatch
	input  logic                    issue_valid,
	input  rob_types_pkg::lane_e    issue_lane,
	input  rv32i_ops_pkg::op_e      issue_op,
	input  rob_types_pkg::rob_tag_t issue_tag,
	input  rv32i_ops_pkg::word_t    issue_a,
	input  rv32i_ops_pkg::word_t    issue_b,
	output logic                    mul_busy,

	// ALU completion bus
	output logic                    alu_done_valid,
	output rob_types_pkg::rob_tag_t alu_done_tag,
	output rv32i_ops_pkg::word_t    alu_done_data,

	// Multiplier completion bus
	output logic                    mul_done_valid,
	output rob_types_pkg::rob_tag_t mul_done_tag,
	output rv32i_ops_pkg::word_t    mul_done_data
);
	import rv32i_ops_pkg::*;
	import rob_types_pkg::*;

	typedef enum logic {
		st_idle,
		st_busy
	} mul_state_e;

	mul_state_e mul_state;
	mul_cnt_t   mul_cnt;
	word_t      mul_a;
	word_t      mul_b;
	rob_tag_t   mul_tag;
	logic       alu_go;
	logic       mul_go;
	logic       mul_last;
	word_t      alu_result;

	function automatic word_t alu_compute(op_e op, word_t a, word_t b);
		word_t res;
		case (op)
			op_add:  res = a + b;
			op_sub:  res = a - b;
			op_and:  res = a & b;
			op_or:   res = a | b;
			op_xor:  res = a ^ b;
			op_sll:  res = a << b[shamt_width-1:0];
			op_srl:  res = a >> b[shamt_width-1:0];
			default: res = '0;
		endcase
		return res;
	endfunction

	assign alu_go     = issue_valid && (issue_lane == lane_alu);
	assign alu_result = alu_compute(issue_op, issue_a, issue_b);

	// ALU lane puts its result on the bus one cycle after issue
	always_ff @(posedge clk) begin
		if (rst) begin
			alu_done_valid <= 1'b0;
		end else begin
			alu_done_valid <= alu_go;
		end
	end

	always_ff @(posedge clk) begin
		if (alu_go) begin
			alu_done_tag  <= issue_tag;
			alu_done_data <= alu_result;
		end
	end

	// Dispatch never issues a multiply while the lane is busy
	assign mul_go   = issue_valid && (issue_lane == lane_mul) && (mul_state == st_idle);
	assign mul_last = (mul_state == st_busy) && (mul_cnt == mul_cnt_t'(1));
	assign mul_busy = (mul_state == st_busy);

	// Counter starts one short since the done flag is itself registered
	always_ff @(posedge clk) begin
		if (rst) begin
			mul_state      <= st_idle;
			mul_cnt        <= '0;
			mul_done_valid <= 1'b0;
		end else begin
			mul_done_valid <= 1'b0;
			case (mul_state)
				st_idle: begin
					if (mul_go) begin
						mul_state <= st_busy;
						mul_cnt   <= mul_cnt_t'(mul_latency - 1);
					end
				end
				st_busy: begin
					mul_cnt <= mul_cnt - 1'b1;
					if (mul_last) begin
						mul_state      <= st_idle;
						mul_done_valid <= 1'b1;
					end
				end
				default: mul_state <= st_idle;
			endcase
		end
	end

	// Operands held for the whole multiply
	always_ff @(posedge clk) begin
		if (mul_go) begin
			mul_a   <= issue_a;
			mul_b   <= issue_b;
			mul_tag <= issue_tag;
		end
		if (mul_last) begin
			mul_done_tag  <= mul_tag;
			mul_done_data <= mul_a * mul_b;
		end
	end

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
	input  logic                    clk,
	input  logic                    rst,

	// Decoded instruction stream
	input  logic                    instr_valid,
	output logic                    instr_ready,
	input  rv32i_ops_pkg::op_e      instr_op,
	input  rv32i_ops_pkg::reg_idx_t instr_rd,
	input  rv32i_ops_pkg::word_t    instr_a,
	input  rv32i_ops_pkg::word_t    instr_b,

	// Tag allocation in the reorder buffer
	output logic                    alloc_valid,
	output rv32i_ops_pkg::reg_idx_t alloc_rd,
	input  logic                    alloc_ready,
	input  rob_types_pkg::rob_tag_t alloc_tag,

	// Issue to the execution lanes
	output logic                    issue_valid,
	output rob_types_pkg::lane_e    issue_lane,
	output rv32i_ops_pkg::op_e      issue_op,
	output rob_types_pkg::rob_tag_t issue_tag,
	output rv32i_ops_pkg::word_t    issue_a,
	output rv32i_ops_pkg::word_t    issue_b,
	input  logic                    mul_busy
);
	import rv32i_ops_pkg::*;
	import rob_types_pkg::*;

	lane_e instr_lane;
	logic  mul_pending;
	logic  lane_free;
	logic  accept;

	// Only multiplies go to the multiplier, everything else to the ALU
	assign instr_lane = (instr_op == op_mul) ? lane_mul : lane_alu;

	// A multiply still in the issue register has claimed the multiplier
	assign mul_pending = issue_valid && (issue_lane == lane_mul);

	// ALU takes one instruction per cycle, so only multiplies can stall here
	assign lane_free = (instr_lane == lane_alu) || (!mul_busy && !mul_pending);

	assign instr_ready = alloc_ready && lane_free;
	assign accept      = instr_valid && instr_ready;

	assign alloc_valid = accept;
	assign alloc_rd    = instr_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= accept;
		end
	end

	// Issue payload carries the tag handed out on the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			issue_lane <= instr_lane;
			issue_op   <= instr_op;
			issue_tag  <= alloc_tag;
			issue_a    <= instr_a;
			issue_b    <= instr_b;
		end
	end

endmodule

// ==== hdl/rob_types_pkg.sv ====
package rob_types_pkg;

	// Reorder buffer geometry
	localparam int rob_size = 8;
	localparam int rob_tag_width = $clog2(rob_size);

	// One extra bit so a full buffer can be told apart from an empty one
	typedef logic [rob_tag_width-1:0] rob_tag_t;
	typedef logic [rob_tag_width:0] rob_cnt_t;

	// Cycles from multiplier issue to its completion bus
	localparam int mul_latency = 4;
	localparam int mul_cnt_width = $clog2(mul_latency);

	typedef logic [mul_cnt_width-1:0] mul_cnt_t;

	// Execution lane selected at dispatch
	typedef enum logic {
		lane_alu = 1'b0,
		lane_mul = 1'b1
	} lane_e;

endpackage

// ==== hdl/rv32i_ops_pkg.sv ====
package rv32i_ops_pkg;

	// Data path width and register file geometry
	localparam int xlen = 32;
	localparam int num_regs = 32;
	localparam int reg_idx_width = $clog2(num_regs);

	// Shifts only look at the low bits of the second operand
	localparam int shamt_width = $clog2(xlen);

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_idx_width-1:0] reg_idx_t;

	// Register-to-register operations handled by the back end
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_sll = 3'd5,
		op_srl = 3'd6,
		op_mul = 3'd7
	} op_e;

endpackage
